//--- hdl/sgb_hook_pkg.sv
package sgb_hook_pkg;

  //////////////////////////////
  // bus and data types
  //////////////////////////////

  // one cycle of the snooped SNES CPU bus
  typedef struct packed {
    logic [23:0] addr;
    logic [7:0]  data;
    logic        wr_strobe;
    logic        rd_strobe;
    logic        cycle_start;
  } snes_bus_t;

  // joypad word, high byte written first, low byte completes it
  typedef logic [15:0] pad_sample_t;

  // cheat_en sits at bit 0 so the MCU flag word maps bit for bit
  typedef struct packed {
    logic wram_present;
    logic buttons_en;
    logic holdoff_en;
    logic irq_en;
    logic nmi_en;
    logic cheat_en;
  } hook_flags_t;

  // snescmd opcodes shared by the SNES side and the button path
  typedef enum logic [7:0] {
    CMD_NONE       = 8'h00,
    CMD_RESET_GAME = 8'h80,
    CMD_RESET_MENU = 8'h81,
    CMD_CHEAT_ON   = 8'h82,
    CMD_CHEAT_OFF  = 8'h83,
    CMD_HOOK_OFF   = 8'h84,
    CMD_HOOK_HOLD  = 8'h85
  } snescmd_op_e;

  typedef enum logic [1:0] {
    BTN_IDLE  = 2'd0,
    BTN_ISSUE = 2'd1
  } btn_state_e;

  //////////////////////////////
  // constants
  //////////////////////////////

  // button combos, L+R held in every one of them
  localparam pad_sample_t PAD_RESET_GAME = 16'h3030;
  localparam pad_sample_t PAD_RESET_MENU = 16'h2070;
  localparam pad_sample_t PAD_HOOK_OFF   = 16'h5030;
  localparam pad_sample_t PAD_HOOK_HOLD  = 16'h1070;

  // save/load selector values
  localparam logic [7:0] SEL_SAVE = 8'h05;
  localparam logic [7:0] SEL_LOAD = 8'h06;

  localparam logic [23:0] VEC_LO_ADDR     = 24'h00FFFC;
  localparam logic [23:0] VEC_HI_ADDR     = 24'h00FFFD;
  localparam logic [8:0]  CMD_ADDR        = 9'h000;
  localparam logic [8:0]  UNLOCK_OFF_ADDR = 9'h1FD;

  // patched reset vector points at the snescmd boot code
  localparam logic [7:0] VEC_LO_DATA = 8'h2A;
  localparam logic [7:0] VEC_HI_DATA = 8'h7D;

  localparam logic [2:0] PGM_FLAGS_IDX = 3'd7;

  // selector from bits 13:12 and 6:4, directions and y/b/a ignored
  function automatic logic [7:0] pad_selector(input pad_sample_t p);
    return {2'b00, p[13:12], 1'b0, p[6:4]};
  endfunction

endpackage

//--- hdl/pad_snoop.sv
`timescale 1ns/1ps

module pad_snoop import sgb_hook_pkg::*; (
  input  logic        clk,
  input  logic        SNES_reset_strobe,
  input  snes_bus_t   bus,
  input  logic        button_enable,
  input  logic        button_addr,
  output pad_sample_t sample,
  output logic        sample_valid
);

  // SGB ROM stores the pad state to WRAM each frame
  // the decoder flags those two locations with button_enable
  logic pad_wr;

  assign pad_wr = bus.wr_strobe && button_enable;

  //////////////////////////////
  // byte capture
  //////////////////////////////

  // button_addr picks which half of the word the write lands in
  always_ff @(posedge clk) begin
    if (pad_wr) begin
      if (button_addr) begin
        sample[15:8] <= bus.data;
      end else begin
        sample[7:0] <= bus.data;
      end
    end
  end

  // low byte is written second and closes the sample
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= pad_wr && !button_addr;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // wr_strobe lasts one clock per bus cycle
  // and a sample never repeats on the very next clock
  a_valid_single: assert property (
    @(posedge clk) disable iff (SNES_reset_strobe)
    sample_valid |=> !sample_valid
  );

endmodule

//--- hdl/pad_fifo.sv
`timescale 1ns/1ps

module pad_fifo import sgb_hook_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic        clk,
  input  logic        SNES_reset_strobe,
  input  pad_sample_t wr_data,
  input  logic        wr,
  input  logic        pop,
  output pad_sample_t head,
  output logic        not_empty
);

  localparam int AW = $clog2(DEPTH);

  // pointers wrap on their own, depth is a power of two
  if ((DEPTH < 2) || ((DEPTH & (DEPTH - 1)) != 0)) begin : g_depth_check
    $error("pad_fifo DEPTH must be a power of two, at least 2");
  end

  pad_sample_t   mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          full;
  logic          do_wr;
  logic          do_rd;

  assign full      = count == (AW + 1)'(DEPTH);
  assign not_empty = count != '0;
  assign head      = mem[rd_ptr];

  // new samples are lost while full, older presses win
  assign do_wr = wr && !full;
  assign do_rd = pop && not_empty;

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  //////////////////////////////
  // pointers and count
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // the consumer must only pop what it sees
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (SNES_reset_strobe)
    pop |-> not_empty
  );

endmodule

//--- hdl/reset_vector_patch.sv
`timescale 1ns/1ps

module reset_vector_patch import sgb_hook_pkg::*; #(
  parameter logic [6:0] UNLOCK_EXIT = 7'd6
) (
  input  logic       clk,
  input  logic       SNES_reset_strobe,
  input  snes_bus_t  bus,
  input  logic       unlock_off,
  output logic [7:0] data_out,
  output logic       cheat_hit,
  output logic       unlock
);

  logic       vec_lo_hit;
  logic       vec_hi_hit;
  logic       vec_hit;
  logic       patch_on;
  // vector fetches still to patch after reset
  logic [1:0] fetch_cnt;
  // exit countdown after the boot code asks to leave
  logic       exit_pending;
  logic [6:0] exit_cnt;

  assign vec_lo_hit = bus.addr == VEC_LO_ADDR;
  assign vec_hi_hit = bus.addr == VEC_HI_ADDR;
  assign vec_hit    = vec_lo_hit || vec_hi_hit;
  assign patch_on   = fetch_cnt != 2'd0;

  //////////////////////////////
  // vector override
  //////////////////////////////

  // combinational from the address since the bus wants the byte this cycle
  assign data_out  = vec_hi_hit ? VEC_HI_DATA : VEC_LO_DATA;
  assign cheat_hit = patch_on && vec_hit;

  // count drops at the start of each vector fetch
  // so starting from three, two whole fetches see the patched bytes
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      fetch_cnt <= 2'd3;
    end else if (bus.cycle_start && vec_hit && patch_on) begin
      fetch_cnt <= fetch_cnt - 2'd1;
    end
  end

  //////////////////////////////
  // snescmd unlock
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      unlock       <= 1'b0;
      exit_pending <= 1'b0;
      exit_cnt     <= '0;
    end else begin
      // CPU is about to jump into snescmd memory
      if (bus.rd_strobe && vec_hi_hit && patch_on) begin
        unlock <= 1'b1;
      end
      // leave a few bus cycles to jump back to the real vector
      if (bus.cycle_start && exit_pending) begin
        if (exit_cnt != '0) begin
          exit_cnt <= exit_cnt - 7'd1;
        end else begin
          unlock       <= 1'b0;
          exit_pending <= 1'b0;
        end
      end
      // a fresh request restarts the countdown
      if (unlock_off) begin
        exit_pending <= 1'b1;
        exit_cnt     <= UNLOCK_EXIT;
      end
    end
  end

  // only the unlocked boot code can ask to leave snescmd
  a_off_while_unlocked: assert property (
    @(posedge clk) disable iff (SNES_reset_strobe)
    unlock_off |-> unlock
  );

endmodule

//--- hdl/hook_control.sv
`timescale 1ns/1ps

module hook_control import sgb_hook_pkg::*; #(
  parameter logic [29:0] HOLDOFF_LONG  = 30'd840000000,
  parameter logic [29:0] HOLDOFF_SHORT = 30'd42000000
) (
  input  logic        clk,
  input  logic        SNES_reset_strobe,
  input  snes_bus_t   bus,
  input  logic        snescmd_enable,
  input  logic        unlock,
  input  logic        pgm_we,
  input  logic [2:0]  pgm_idx,
  input  logic [31:0] pgm_in,
  input  logic        button_fired,
  output hook_flags_t flags,
  output logic        hooks_live,
  output logic        unlock_off
);

  logic        cmd_wr;
  logic        cmd_at_op;
  logic        hold_cmd;
  logic        mcu_flags_wr;
  logic [29:0] holdoff_cnt;

  // only the boot code may talk to us, so the write must be unlocked
  assign cmd_wr       = unlock && snescmd_enable && bus.wr_strobe;
  assign cmd_at_op    = cmd_wr && (bus.addr[8:0] == CMD_ADDR);
  assign hold_cmd     = cmd_at_op && (bus.data == CMD_HOOK_HOLD);
  assign mcu_flags_wr = pgm_we && (pgm_idx == PGM_FLAGS_IDX);

  //////////////////////////////
  // flags and command decode
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      flags      <= '0;
      unlock_off <= 1'b0;
    end else begin
      unlock_off <= 1'b0;
      // SNES side wins over the MCU in the same cycle
      if (cmd_wr) begin
        if (bus.addr[8:0] == CMD_ADDR) begin
          case (bus.data)
            CMD_CHEAT_ON: flags.cheat_en <= 1'b1;
            CMD_CHEAT_OFF: flags.cheat_en <= 1'b0;
            CMD_HOOK_OFF: begin
              flags.nmi_en <= 1'b0;
              flags.irq_en <= 1'b0;
            end
            default: ;
          endcase
        end else if (bus.addr[8:0] == UNLOCK_OFF_ADDR) begin
          unlock_off <= 1'b1;
        end
      end else if (mcu_flags_wr) begin
        // bits 13:8 clear, bits 5:0 set, set applied last
        flags <= hook_flags_t'((flags & ~pgm_in[13:8]) | pgm_in[5:0]);
      end
    end
  end

  //////////////////////////////
  // hold-off timer
  //////////////////////////////

  // reset picks up the hold-off flag before it gets cleared
  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      holdoff_cnt <= flags.holdoff_en ? HOLDOFF_LONG : '0;
    end else if (hold_cmd) begin
      holdoff_cnt <= HOLDOFF_LONG;
    end else if (button_fired) begin
      // short pause so one press fires once
      holdoff_cnt <= HOLDOFF_SHORT;
    end else if (holdoff_cnt != '0) begin
      holdoff_cnt <= holdoff_cnt - 30'd1;
    end
  end

  assign hooks_live = holdoff_cnt == '0;

endmodule

//--- hdl/button_cmd.sv
`timescale 1ns/1ps

module button_cmd import sgb_hook_pkg::*; (
  input  logic        clk,
  input  logic        SNES_reset_strobe,
  input  pad_sample_t head,
  input  logic        not_empty,
  input  hook_flags_t flags,
  input  logic        hooks_live,
  input  logic        unlock,
  input  logic        snescmd_rdy,
  output logic        pop,
  output logic        snescmd_we,
  output logic [8:0]  snescmd_addr,
  output snescmd_op_e snescmd_data,
  output logic        ctx_valid,
  output logic        ctx_mode,
  output logic        button_fired
);

  btn_state_e  state;
  pad_sample_t cmd_q;
  snescmd_op_e op;
  logic [7:0]  sel;
  logic        is_combo;
  logic        is_save;
  logic        is_load;
  logic        keep;
  logic        issuing;

  //////////////////////////////
  // sample decode
  //////////////////////////////

  always_comb begin
    case (cmd_q)
      PAD_RESET_GAME: op = CMD_RESET_GAME;
      PAD_RESET_MENU: op = CMD_RESET_MENU;
      PAD_HOOK_OFF:   op = CMD_HOOK_OFF;
      PAD_HOOK_HOLD:  op = CMD_HOOK_HOLD;
      default:        op = CMD_NONE;
    endcase
  end

  assign is_combo = op != CMD_NONE;
  assign sel      = pad_selector(cmd_q);
  assign is_save  = sel == SEL_SAVE;
  assign is_load  = sel == SEL_LOAD;
  assign issuing  = state == BTN_ISSUE;

  // stay off the snescmd port while the boot code owns it
  assign keep = !unlock && (flags.nmi_en || flags.irq_en) && flags.buttons_en;

  // samples wait in the FIFO while hold-off runs so none get lost
  assign pop = (state == BTN_IDLE) && not_empty && hooks_live;

  //////////////////////////////
  // outputs
  //////////////////////////////

  // write goes out in the first cycle the port is ready
  assign snescmd_we   = issuing && is_combo && snescmd_rdy;
  assign snescmd_addr = CMD_ADDR;
  assign snescmd_data = op;

  // save states piggyback on the cheat enable
  assign ctx_valid    = issuing && !is_combo && (is_save || is_load) && flags.cheat_en;
  // low for save and high for load
  assign ctx_mode     = is_load;
  assign button_fired = snescmd_we || ctx_valid;

  // sample register loads on every pop
  always_ff @(posedge clk) begin
    if (pop) begin
      cmd_q <= head;
    end
  end

  always_ff @(posedge clk) begin
    if (SNES_reset_strobe) begin
      state <= BTN_IDLE;
    end else begin
      case (state)
        BTN_IDLE: if (pop && keep) state <= BTN_ISSUE;
        // unknown words and ctx pulses leave after one cycle
        BTN_ISSUE: if (!is_combo || snescmd_rdy) state <= BTN_IDLE;
        default: state <= BTN_IDLE;
      endcase
    end
  end

  // every action must start a hold-off before the next sample is taken
  a_fire_holds_off: assert property (
    @(posedge clk) disable iff (SNES_reset_strobe)
    button_fired |=> !hooks_live
  );

endmodule

//--- hdl/sgb_hook_top.sv
`timescale 1ns/1ps

module sgb_hook_top import sgb_hook_pkg::*; #(
  parameter logic [29:0] HOLDOFF_LONG  = 30'd840000000,
  parameter logic [29:0] HOLDOFF_SHORT = 30'd42000000,
  parameter logic [6:0]  UNLOCK_EXIT   = 7'd6,
  parameter int          FIFO_DEPTH    = 4
) (
  input  logic        clk,
  input  logic        SNES_reset_strobe,
  // SNES pins, already synchronized
  input  logic [23:0] snes_addr,
  input  logic [7:0]  snes_data,
  input  logic        snes_wr_strobe,
  input  logic        snes_rd_strobe,
  input  logic        snes_cycle_start,
  // address decoder results
  input  logic        snescmd_enable,
  input  logic        button_enable,
  input  logic        button_addr,
  // MCU program port
  input  logic        pgm_we,
  input  logic [2:0]  pgm_idx,
  input  logic [31:0] pgm_in,
  input  logic        snescmd_rdy,
  output logic [7:0]  data_out,
  output logic        cheat_hit,
  output logic        snescmd_unlock,
  output logic        snescmd_we,
  output logic [8:0]  snescmd_addr,
  output snescmd_op_e snescmd_data,
  output logic        ctx_valid,
  output logic        ctx_mode
);

  snes_bus_t   snes_bus;
  pad_sample_t sample;
  logic        sample_valid;
  pad_sample_t head;
  logic        not_empty;
  logic        pop;
  hook_flags_t flags;
  logic        hooks_live;
  logic        unlock_off;
  logic        button_fired;

  assign snes_bus = '{addr: snes_addr, data: snes_data, wr_strobe: snes_wr_strobe,
                      rd_strobe: snes_rd_strobe, cycle_start: snes_cycle_start};

  //////////////////////////////
  // boot path
  //////////////////////////////

  reset_vector_patch #(.UNLOCK_EXIT(UNLOCK_EXIT)) i_vec (
    .clk, .SNES_reset_strobe, .bus(snes_bus), .unlock_off,
    .data_out, .cheat_hit, .unlock(snescmd_unlock)
  );

  hook_control #(.HOLDOFF_LONG(HOLDOFF_LONG), .HOLDOFF_SHORT(HOLDOFF_SHORT)) i_ctrl (
    .clk, .SNES_reset_strobe, .bus(snes_bus), .snescmd_enable, .unlock(snescmd_unlock),
    .pgm_we, .pgm_idx, .pgm_in, .button_fired, .flags, .hooks_live, .unlock_off
  );

  //////////////////////////////
  // button path
  //////////////////////////////

  pad_snoop i_snoop (
    .clk, .SNES_reset_strobe, .bus(snes_bus), .button_enable, .button_addr,
    .sample, .sample_valid
  );

  pad_fifo #(.DEPTH(FIFO_DEPTH)) i_fifo (
    .clk, .SNES_reset_strobe, .wr_data(sample), .wr(sample_valid), .pop,
    .head, .not_empty
  );

  button_cmd i_btn (
    .clk, .SNES_reset_strobe, .head, .not_empty, .flags, .hooks_live,
    .unlock(snescmd_unlock), .snescmd_rdy, .pop, .snescmd_we, .snescmd_addr,
    .snescmd_data, .ctx_valid, .ctx_mode, .button_fired
  );

endmodule

//--- testbench/tb_sgb_hook_model.svh
`ifndef TB_SGB_HOOK_MODEL_SVH
`define TB_SGB_HOOK_MODEL_SVH

//////////////////////////////
// reference model
//////////////////////////////

// opcode a pad word should turn into
// only an exact match of one of the four combos counts
function automatic logic [7:0] expected_opcode(input logic [15:0] p);
  case (p)
    16'h3030: return 8'h80;
    16'h2070: return 8'h81;
    16'h5030: return 8'h84;
    16'h1070: return 8'h85;
    default:  return 8'h00;
  endcase
endfunction

// {valid, mode} of the context pulse, mode 1 is load
// save selector 05h and load selector 06h need bits 13:12 clear
function automatic logic [1:0] expected_ctx(input logic [15:0] p, input logic cheat_en);
  logic save_sel;
  logic load_sel;
  save_sel = (p[13:12] == 2'b00) && (p[6:4] == 3'b101);
  load_sel = (p[13:12] == 2'b00) && (p[6:4] == 3'b110);
  // a combo is never read as a selector
  if (expected_opcode(p) != 8'h00 || !cheat_en) begin
    return 2'b00;
  end
  return {save_sel || load_sel, load_sel};
endfunction

// {cheat_hit, data_out} for a read of addr
// fetch_no counts vector fetches since reset, only the first two are patched
function automatic logic [8:0] expected_vector(input logic [23:0] addr, input int fetch_no);
  logic on_vector;
  on_vector = (addr == 24'h00FFFC) || (addr == 24'h00FFFD);
  return {on_vector && (fetch_no < 2), addr[0] ? 8'h7D : 8'h2A};
endfunction

// plain 32 bit LCG, upper bits are the useful ones
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

`endif

//--- testbench/tb_sgb_hook.sv
`timescale 1ns/1ps

module tb_sgb_hook import sgb_hook_pkg::*; ();

  localparam int CLK_PERIOD    = 40;
  localparam int HOLDOFF_LONG  = 400;
  localparam int HOLDOFF_SHORT = 40;
  localparam int UNLOCK_EXIT   = 6;
  localparam int FIFO_DEPTH    = 4;
  // cycles snescmd_rdy stays low in the back-pressure test
  localparam int RDY_WAIT      = 100;
  localparam int SETTLE        = 2 * HOLDOFF_SHORT;
  localparam int ACC_IDLE      = 0;
  localparam int ACC_RD        = 1;
  localparam int ACC_WR        = 2;
  // reset, two fetches and the unlock exit, in clocks
  localparam int BOOT_CYCLES   = 12 + 3 * (UNLOCK_EXIT + 3);
  localparam int TEST_CYCLES   = 6 * BOOT_CYCLES + 40 * (HOLDOFF_SHORT + 20) +
                                 HOLDOFF_LONG + RDY_WAIT;

  // one snescmd write or context pulse the DUT owes us
  typedef struct packed {
    logic        is_ctx;
    logic [7:0]  op;
    logic        mode;
    logic [31:0] not_before;
  } exp_event_t;

  logic        clk;
  logic        SNES_reset_strobe;
  logic [23:0] snes_addr;
  logic [7:0]  snes_data;
  logic        snes_wr_strobe;
  logic        snes_rd_strobe;
  logic        snes_cycle_start;
  logic        snescmd_enable;
  logic        button_enable;
  logic        button_addr;
  logic        pgm_we;
  logic [2:0]  pgm_idx;
  logic [31:0] pgm_in;
  logic        snescmd_rdy;
  logic [7:0]  data_out;
  logic        cheat_hit;
  logic        snescmd_unlock;
  logic        snescmd_we;
  logic [8:0]  snescmd_addr;
  snescmd_op_e snescmd_data;
  logic        ctx_valid;
  logic        ctx_mode;

  exp_event_t  exp_q[$];
  int          errors;
  int          checks;
  int          events;
  logic [31:0] cycle;
  logic [31:0] last_event;
  logic        gap_valid;
  // mirror of what the flags and unlock should be
  hook_flags_t model_flags;
  logic        model_unlock;
  int          vec_fetches;
  logic [31:0] lcg_state;

  `include "tb_sgb_hook_model.svh"

  sgb_hook_top #(
    .HOLDOFF_LONG(HOLDOFF_LONG), .HOLDOFF_SHORT(HOLDOFF_SHORT),
    .UNLOCK_EXIT(UNLOCK_EXIT), .FIFO_DEPTH(FIFO_DEPTH)
  ) i_dut (
    .clk, .SNES_reset_strobe, .snes_addr, .snes_data, .snes_wr_strobe,
    .snes_rd_strobe, .snes_cycle_start, .snescmd_enable, .button_enable,
    .button_addr, .pgm_we, .pgm_idx, .pgm_in, .snescmd_rdy, .data_out,
    .cheat_hit, .snescmd_unlock, .snescmd_we, .snescmd_addr, .snescmd_data,
    .ctx_valid, .ctx_mode
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    errors++;
    $display("FAIL time=%0t signal=%s expected=%0h got=%0h", $time, name, exp, got);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR time=%0t %s", $time, msg);
  endtask

  //////////////////////////////
  // bus and MCU drivers
  //////////////////////////////

  task automatic reset_dut();
    @(posedge clk);
    SNES_reset_strobe <= 1'b1;
    model_flags  = '0;
    model_unlock = 1'b0;
    vec_fetches  = 0;
    gap_valid    = 1'b0;
    repeat (5) @(posedge clk);
    SNES_reset_strobe <= 1'b0;
    @(negedge clk);
    checks++;
    if (snescmd_unlock !== 1'b0) report_mismatch("snescmd_unlock", 0, snescmd_unlock);
    if (snescmd_we !== 1'b0) report_mismatch("snescmd_we", 0, snescmd_we);
    if (ctx_valid !== 1'b0) report_mismatch("ctx_valid", 0, ctx_valid);
  endtask

  // one SNES bus cycle: cycle_start, then the strobe, then idle
  // dec is {snescmd_enable, button_enable, button_addr}
  task automatic bus_access(input logic [23:0] addr, input logic [7:0] data,
                            input int kind, input logic [2:0] dec,
                            output logic hit, output logic [7:0] dout);
    @(posedge clk);
    snes_addr        <= addr;
    snes_data        <= data;
    snes_cycle_start <= 1'b1;
    {snescmd_enable, button_enable, button_addr} <= dec;
    @(posedge clk);
    snes_cycle_start <= 1'b0;
    snes_rd_strobe   <= kind == ACC_RD;
    snes_wr_strobe   <= kind == ACC_WR;
    // override is combinational, look at it mid strobe
    @(negedge clk);
    hit  = cheat_hit;
    dout = data_out;
    @(posedge clk);
    snes_rd_strobe <= 1'b0;
    snes_wr_strobe <= 1'b0;
    {snescmd_enable, button_enable, button_addr} <= 3'b000;
  endtask

  task automatic vector_fetch(input logic [23:0] addr);
    logic       hit;
    logic [7:0] dout;
    logic [8:0] exp;
    exp = expected_vector(addr, vec_fetches);
    bus_access(addr, 8'h00, ACC_RD, 3'b000, hit, dout);
    vec_fetches++;
    checks++;
    if (hit !== exp[8]) report_mismatch("cheat_hit", exp[8], hit);
    if (exp[8] && dout !== exp[7:0]) report_mismatch("data_out", exp[7:0], dout);
  endtask

  // reset, then the two patched fetches that open snescmd
  task automatic boot_unlock();
    reset_dut();
    vector_fetch(VEC_LO_ADDR);
    vector_fetch(VEC_HI_ADDR);
    @(negedge clk);
    model_unlock = 1'b1;
    checks++;
    if (snescmd_unlock !== 1'b1) report_mismatch("snescmd_unlock", 1, snescmd_unlock);
  endtask

  task automatic snescmd_write(input logic [8:0] addr9, input logic [7:0] data);
    logic       hit;
    logic [7:0] dout;
    bus_access({15'h0015, addr9}, data, ACC_WR, 3'b100, hit, dout);
    if (model_unlock && addr9 == CMD_ADDR) begin
      case (data)
        CMD_CHEAT_ON: model_flags.cheat_en = 1'b1;
        CMD_CHEAT_OFF: model_flags.cheat_en = 1'b0;
        CMD_HOOK_OFF: begin
          model_flags.nmi_en = 1'b0;
          model_flags.irq_en = 1'b0;
        end
        default: ;
      endcase
    end
  endtask

  // unlock must hold for UNLOCK_EXIT bus cycles and drop on the next
  task automatic leave_unlock();
    logic       hit;
    logic [7:0] dout;
    snescmd_write(UNLOCK_OFF_ADDR, 8'h00);
    for (int i = 1; i <= UNLOCK_EXIT + 1; i++) begin
      bus_access(24'h008000 + i, 8'h00, ACC_IDLE, 3'b000, hit, dout);
      @(negedge clk);
      checks++;
      if (snescmd_unlock !== (i <= UNLOCK_EXIT)) begin
        report_mismatch("snescmd_unlock", i <= UNLOCK_EXIT, snescmd_unlock);
      end
    end
    model_unlock = 1'b0;
  endtask

  // bits 13:8 clear flags, bits 5:0 set them
  task automatic mcu_flags(input logic [5:0] clr, input logic [5:0] set);
    @(posedge clk);
    pgm_we  <= 1'b1;
    pgm_idx <= PGM_FLAGS_IDX;
    pgm_in  <= {18'h0, clr, 2'b00, set};
    @(posedge clk);
    pgm_we <= 1'b0;
    model_flags = hook_flags_t'((model_flags & ~clr) | set);
  endtask

  // queue what the pad word should cause, then write high and low byte
  task automatic send_pad(input pad_sample_t p, input logic [31:0] not_before);
    logic [7:0] op;
    logic [1:0] ctx;
    logic       live;
    exp_event_t e;
    logic       hit;
    logic [7:0] dout;
    op   = expected_opcode(p);
    ctx  = expected_ctx(p, model_flags.cheat_en);
    live = !model_unlock && (model_flags.nmi_en || model_flags.irq_en) &&
           model_flags.buttons_en;
    e.is_ctx     = op == 8'h00;
    e.op         = op;
    e.mode       = ctx[0];
    e.not_before = not_before;
    if (live && (op != 8'h00 || ctx[1])) exp_q.push_back(e);
    bus_access(24'h7E0F00, p[15:8], ACC_WR, 3'b011, hit, dout);
    bus_access(24'h7E0F01, p[7:0], ACC_WR, 3'b010, hit, dout);
  endtask

  task automatic next_plain_word(output pad_sample_t w);
    logic [1:0] ctx;
    do begin
      lcg_state = lcg_next(lcg_state);
      w         = lcg_state[23:8];
      ctx       = expected_ctx(w, 1'b1);
    end while (expected_opcode(w) != 8'h00 || ctx[1]);
  endtask

  // wait for every queued event, then idle a while to catch extras
  task automatic drain_events(input int limit);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      report_error($sformatf("%0d expected events never issued", exp_q.size()));
      exp_q.delete();
    end
    repeat (SETTLE) @(posedge clk);
  endtask

  //////////////////////////////
  // compare process
  //////////////////////////////

  always @(negedge clk) begin : compare
    exp_event_t e;
    if (!SNES_reset_strobe && (snescmd_we || ctx_valid)) begin
      events++;
      checks++;
      if (exp_q.size() == 0) begin
        report_error(snescmd_we ? "snescmd write with no command pending"
                                : "context pulse with nothing pending");
      end else begin
        e = exp_q.pop_front();
        if (ctx_valid !== e.is_ctx) report_mismatch("ctx_valid", e.is_ctx, ctx_valid);
        if (e.is_ctx && ctx_mode !== e.mode) report_mismatch("ctx_mode", e.mode, ctx_mode);
        if (!e.is_ctx && snescmd_data !== e.op) begin
          report_mismatch("snescmd_data", e.op, snescmd_data);
        end
        if (!e.is_ctx && snescmd_addr !== CMD_ADDR) begin
          report_mismatch("snescmd_addr", CMD_ADDR, snescmd_addr);
        end
        if (cycle < e.not_before) begin
          report_error($sformatf("event at cycle %0d came before cycle %0d",
                                 cycle, e.not_before));
        end
      end
      // each action reloads the short hold-off
      if (gap_valid && (cycle - last_event) <= HOLDOFF_SHORT) begin
        report_error($sformatf("events only %0d cycles apart", cycle - last_event));
      end
      gap_valid  = 1'b1;
      last_event = cycle;
    end
  end

  initial begin : watchdog
    #(2 * TEST_CYCLES * CLK_PERIOD);
    errors++;
    $display("ERROR time=%0t watchdog expired before the sequence finished", $time);
    $display("summary: checks=%0d events=%0d errors=%0d", checks, events, errors);
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin : main
    pad_sample_t w;
    logic [31:0] t0;
    SNES_reset_strobe = 1'b1;
    snes_addr         = '0;
    snes_data         = '0;
    snes_wr_strobe    = 1'b0;
    snes_rd_strobe    = 1'b0;
    snes_cycle_start  = 1'b0;
    snescmd_enable    = 1'b0;
    button_enable     = 1'b0;
    button_addr       = 1'b0;
    pgm_we            = 1'b0;
    pgm_idx           = '0;
    pgm_in            = '0;
    snescmd_rdy       = 1'b1;
    cycle             = '0;
    last_event        = '0;
    gap_valid         = 1'b0;
    errors            = 0;
    checks            = 0;
    events            = 0;
    lcg_state         = 32'h6e81;

    // patched vector, then a third fetch sees the real one
    boot_unlock();
    vector_fetch(VEC_LO_ADDR);
    leave_unlock();

    // combos one at a time, then random words that must stay quiet
    mcu_flags(6'h00, 6'h12);
    send_pad(PAD_RESET_GAME, 0);
    drain_events(4 * HOLDOFF_SHORT);
    send_pad(PAD_RESET_MENU, 0);
    drain_events(4 * HOLDOFF_SHORT);
    send_pad(PAD_HOOK_OFF, 0);
    drain_events(4 * HOLDOFF_SHORT);
    send_pad(PAD_HOOK_HOLD, 0);
    drain_events(4 * HOLDOFF_SHORT);
    repeat (6) begin
      next_plain_word(w);
      send_pad(w, 0);
    end
    drain_events(4 * HOLDOFF_SHORT);

    // port not ready, one command waits and three queue behind it
    @(posedge clk);
    snescmd_rdy <= 1'b0;
    t0 = cycle + RDY_WAIT;
    send_pad(PAD_RESET_GAME, t0);
    send_pad(PAD_RESET_MENU, t0);
    send_pad(PAD_HOOK_HOLD, t0);
    send_pad(PAD_HOOK_OFF, t0);
    while (cycle < t0) @(posedge clk);
    checks++;
    if (exp_q.size() != 4) report_error("command lost or issued while snescmd_rdy was low");
    snescmd_rdy <= 1'b1;
    drain_events(8 * HOLDOFF_SHORT);

    // save and load with cheats on
    boot_unlock();
    mcu_flags(6'h00, 6'h13);
    leave_unlock();
    send_pad(16'h0050, 0);
    send_pad(16'h0060, 0);
    drain_events(4 * HOLDOFF_SHORT);

    // cheats off from the SNES side, a combo still goes through
    boot_unlock();
    mcu_flags(6'h00, 6'h13);
    snescmd_write(CMD_ADDR, CMD_CHEAT_OFF);
    leave_unlock();
    send_pad(16'h0050, 0);
    send_pad(16'h0060, 0);
    send_pad(PAD_RESET_MENU, 0);
    drain_events(4 * HOLDOFF_SHORT);

    // long hold-off from the SNES side
    boot_unlock();
    mcu_flags(6'h00, 6'h12);
    snescmd_write(CMD_ADDR, CMD_HOOK_HOLD);
    t0 = cycle + HOLDOFF_LONG;
    leave_unlock();
    send_pad(PAD_RESET_GAME, t0);
    drain_events(HOLDOFF_LONG + 4 * HOLDOFF_SHORT);

    // hooks off until the MCU turns NMI back on
    boot_unlock();
    mcu_flags(6'h00, 6'h12);
    snescmd_write(CMD_ADDR, CMD_HOOK_OFF);
    leave_unlock();
    send_pad(PAD_HOOK_HOLD, 0);
    repeat (SETTLE) @(posedge clk);
    mcu_flags(6'h00, 6'h02);
    send_pad(PAD_HOOK_HOLD, 0);
    drain_events(4 * HOLDOFF_SHORT);

    $display("summary: checks=%0d events=%0d errors=%0d", checks, events, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+testbench
hdl/sgb_hook_pkg.sv
hdl/pad_snoop.sv
hdl/pad_fifo.sv
hdl/reset_vector_patch.sv
hdl/hook_control.sv
hdl/button_cmd.sv
hdl/sgb_hook_top.sv
testbench/tb_sgb_hook.sv
